//--- list.f
+incdir+source
source/impulse_pkg.sv
source/impulse_generator.sv
source/impulse_recorder.sv
source/impulse_line_store.sv
source/impulse_capture_top.sv
verif/audio_clock_gen.sv
verif/impulse_capture_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module impulse_capture_tb -Mdir obj_dir
	./obj_dir/Vimpulse_capture_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verif/impulse_capture_tb.sv
`timescale 1ns/1ps

`include "impulse_defines.svh"

module impulse_capture_tb;

    localparam int clk_period = 40;
    localparam int trig_spacing = 4;
    localparam int num_lines = `IMPULSE_LENGTH / `WORDS_PER_LINE;
    // four captures, the longest delay and the line reads
    localparam int test_periods = 4 * (`IMPULSE_LENGTH + 4) + 5 + 40;
    localparam impulse_pkg::sample_t amp = `IMPULSE_AMP;

    logic audio_clk;
    logic rst_in;
    logic audio_trigger = 1'b0;
    logic record_trigger = 1'b0;
    impulse_pkg::delay_t delay_length = '0;
    impulse_pkg::sample_t mic_in = '0;
    logic rd_req = 1'b0;
    impulse_pkg::line_addr_t rd_line = '0;
    impulse_pkg::sample_t speaker_out;
    logic impulse_recorded;
    logic rd_ack;
    impulse_pkg::line_t rd_data;

    integer seed = 32'h308d143b;
    integer rnd;
    int trig_phase = 0;
    int trig_count = 0;
    int rise_count = 0;
    logic recorded_prev = 1'b0;
    impulse_pkg::sample_t mic_log[$];
    impulse_pkg::line_t exp_lines[num_lines];
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int last_first_idx = -1;

    audio_clock_gen i_clock_gen (
        .audio_clk(audio_clk),
        .rst_in(rst_in)
    );

    impulse_capture_top i_dut (
        .audio_clk(audio_clk),
        .rst_in(rst_in),
        .audio_trigger(audio_trigger),
        .record_trigger(record_trigger),
        .delay_length(delay_length),
        .mic_in(mic_in),
        .rd_req(rd_req),
        .rd_line(rd_line),
        .speaker_out(speaker_out),
        .impulse_recorded(impulse_recorded),
        .rd_ack(rd_ack),
        .rd_data(rd_data)
    );

    // sample strobe every fourth clock
    always @(posedge audio_clk) begin
        if (rst_in) begin
            trig_phase <= 0;
            audio_trigger <= 1'b0;
        end else begin
            trig_phase <= (trig_phase + 1) % trig_spacing;
            audio_trigger <= (trig_phase == trig_spacing - 1);
        end
    end

    // microphone model
    // log index is the trigger number
    always @(posedge audio_clk) begin
        if (!rst_in && audio_trigger) begin
            mic_log.push_back(mic_in);
            trig_count <= trig_count + 1;
            rnd = $random(seed);
            mic_in <= rnd[15:0];
        end
    end

    always @(posedge audio_clk) begin
        if (!rst_in && impulse_recorded && !recorded_prev) begin
            rise_count <= rise_count + 1;
        end
        recorded_prev <= impulse_recorded;
    end

    initial begin
        #(test_periods * trig_spacing * clk_period * 2);
        $display("Error: run did not finish within %0d sample periods", 2 * test_periods);
        $display("Result: FAILED");
        $finish;
    end

    task automatic compare_sample(input impulse_pkg::sample_t got,
                                  input impulse_pkg::sample_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_line(input impulse_pkg::line_t got,
                                input impulse_pkg::line_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic pulse_record_trigger();
        @(posedge audio_clk);
        record_trigger <= 1'b1;
        @(posedge audio_clk);
        record_trigger <= 1'b0;
    endtask

    // returns the trigger count once the impulse has ended, -1 if none came
    task automatic watch_impulse(output int end_count);
        int waited;
        waited = 0;
        end_count = -1;
        @(negedge audio_clk);
        while (speaker_out !== amp && waited < 4 * trig_spacing) begin
            @(negedge audio_clk);
            waited++;
        end
        if (speaker_out !== amp) begin
            errors++;
            $display("Error at %0t: no impulse on speaker_out after a record request", $time);
        end else begin
            repeat (trig_spacing - 1) begin
                @(negedge audio_clk);
                compare_sample(speaker_out, amp, "speaker_out during impulse");
            end
            @(negedge audio_clk);
            compare_sample(speaker_out, '0, "speaker_out after impulse");
            end_count = trig_count;
        end
    endtask

    task automatic await_recorded(input int delay);
        int waited;
        int limit;
        waited = 0;
        limit = (delay + `IMPULSE_LENGTH + 4) * trig_spacing;
        @(negedge audio_clk);
        while (impulse_recorded !== 1'b1 && waited < limit) begin
            @(negedge audio_clk);
            waited++;
        end
        if (impulse_recorded !== 1'b1) begin
            errors++;
            $display("Error at %0t: impulse_recorded never rose", $time);
        end
    endtask

    // sample k of a line sits in the k-th word from the top
    task automatic expected_lines(input int first_idx);
        int idx;
        for (int l = 0; l < num_lines; l++) begin
            exp_lines[l] = '0;
            for (int k = 0; k < `WORDS_PER_LINE; k++) begin
                idx = first_idx + l * `WORDS_PER_LINE + k;
                exp_lines[l][(`WORDS_PER_LINE - 1 - k) * `SAMPLE_WIDTH +: `SAMPLE_WIDTH] =
                    mic_log[idx];
            end
        end
    endtask

    task automatic run_capture(input impulse_pkg::delay_t delay, input bit retrigger,
                               output int first_idx);
        int end_count;
        @(posedge audio_clk);
        delay_length <= delay;
        pulse_record_trigger();
        watch_impulse(end_count);
        compare_flag(impulse_recorded, 1'b0, "impulse_recorded after new request");
        if (end_count < 0) begin
            first_idx = -1;
        end else begin
            first_idx = end_count + int'(delay);
            if (retrigger) begin
                while (trig_count < first_idx + 10) begin
                    @(negedge audio_clk);
                end
                pulse_record_trigger();
            end
            await_recorded(int'(delay));
        end
    endtask

    task automatic read_line(input impulse_pkg::line_addr_t addr,
                             output impulse_pkg::line_t data);
        int waited;
        bit answered;
        waited = 0;
        answered = 1'b0;
        data = '0;
        @(negedge audio_clk);
        compare_flag(rd_ack, 1'b0, "rd_ack before request");
        @(posedge audio_clk);
        rd_line <= addr;
        rd_req <= 1'b1;
        @(negedge audio_clk);
        while (rd_ack !== 1'b1 && waited < 8) begin
            @(negedge audio_clk);
            waited++;
        end
        if (rd_ack !== 1'b1) begin
            errors++;
            $display("Error at %0t: rd_ack never answered the read of line %0d", $time, addr);
        end else begin
            answered = 1'b1;
            data = rd_data;
            // the store holds while the host stalls
            repeat (3) begin
                @(negedge audio_clk);
                compare_flag(rd_ack, 1'b1, "rd_ack while rd_req held");
                compare_line(rd_data, data, "rd_data during ack");
            end
        end
        @(posedge audio_clk);
        rd_req <= 1'b0;
        @(negedge audio_clk);
        compare_flag(rd_ack, 1'b1, "rd_ack in the cycle rd_req falls");
        if (answered) begin
            compare_line(rd_data, data, "rd_data in the cycle rd_req falls");
        end
        @(negedge audio_clk);
        compare_flag(rd_ack, 1'b0, "rd_ack after release");
        @(negedge audio_clk);
        compare_flag(rd_ack, 1'b0, "rd_ack without request");
    endtask

    task automatic verify_lines(input int first_idx, input bit reverse);
        impulse_pkg::line_t data;
        impulse_pkg::line_addr_t addr;
        if (first_idx < 0 || mic_log.size() < first_idx + `IMPULSE_LENGTH) begin
            errors++;
            $display("Error at %0t: microphone log does not cover the capture", $time);
        end else begin
            expected_lines(first_idx);
            for (int n = 0; n < num_lines; n++) begin
                addr = reverse ? impulse_pkg::line_addr_t'(num_lines - 1 - n)
                               : impulse_pkg::line_addr_t'(n);
                read_line(addr, data);
                compare_line(data, exp_lines[addr], $sformatf("line %0d", addr));
            end
        end
    endtask

    task automatic reset_state();
        int mark;
        mark = errors;
        @(negedge audio_clk);
        compare_sample(speaker_out, '0, "speaker_out after reset");
        compare_flag(impulse_recorded, 1'b0, "impulse_recorded after reset");
        compare_flag(rd_ack, 1'b0, "rd_ack after reset");
        report_test("reset_state", mark);
    endtask

    task automatic impulse_output();
        int mark;
        int first_idx;
        mark = errors;
        run_capture(16'd0, 1'b0, first_idx);
        report_test("impulse_output", mark);
    endtask

    task automatic zero_delay_capture();
        int mark;
        int first_idx;
        mark = errors;
        run_capture(16'd0, 1'b0, first_idx);
        compare_flag(impulse_recorded, 1'b1, "impulse_recorded after capture");
        verify_lines(first_idx, 1'b0);
        report_test("zero_delay_capture", mark);
    endtask

    task automatic delayed_capture();
        int mark;
        int first_idx;
        mark = errors;
        run_capture(16'd5, 1'b0, first_idx);
        verify_lines(first_idx, 1'b0);
        report_test("delayed_capture", mark);
    endtask

    task automatic ignored_retrigger();
        int mark;
        int first_idx;
        int rises_before;
        mark = errors;
        rises_before = rise_count;
        run_capture(16'd0, 1'b1, first_idx);
        // let any stray completion show up
        repeat (4 * trig_spacing) @(negedge audio_clk);
        compare_flag(rise_count - rises_before == 1, 1'b1, "impulse_recorded rose once");
        compare_flag(impulse_recorded, 1'b1, "impulse_recorded held");
        verify_lines(first_idx, 1'b0);
        last_first_idx = first_idx;
        report_test("ignored_retrigger", mark);
    endtask

    task automatic read_handshake();
        int mark;
        mark = errors;
        verify_lines(last_first_idx, 1'b1);
        report_test("read_handshake", mark);
    endtask

    initial begin
        while (rst_in !== 1'b0) begin
            @(negedge audio_clk);
        end
        reset_state();
        impulse_output();
        zero_delay_capture();
        delayed_capture();
        ignored_retrigger();
        read_handshake();
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- verif/audio_clock_gen.sv
`timescale 1ns/1ps

module audio_clock_gen (
    output logic audio_clk,
    output logic rst_in
);

    // 40 ns period
    initial begin
        audio_clk = 1'b0;
        forever #20 audio_clk = ~audio_clk;
    end

    // reset spans three rising edges
    initial begin
        rst_in = 1'b1;
        repeat (3) @(posedge audio_clk);
        rst_in <= 1'b0;
    end

endmodule

//--- source/impulse_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "impulse_defines.svh"

module impulse_capture_top (
    input wire audio_clk,
    input wire rst_in,
    input wire audio_trigger,
    input wire record_trigger,
    input wire impulse_pkg::delay_t delay_length,
    input wire impulse_pkg::sample_t mic_in,
    input wire rd_req,
    input wire impulse_pkg::line_addr_t rd_line,
    output impulse_pkg::sample_t speaker_out,
    output logic impulse_recorded,
    output logic rd_ack,
    output impulse_pkg::line_t rd_data
);

    logic impulse_done;
    logic wr_en;
    impulse_pkg::line_addr_t wr_line;
    impulse_pkg::line_t wr_data;

    impulse_generator i_generator (
        .audio_clk(audio_clk),
        .rst_in(rst_in),
        .audio_trigger(audio_trigger),
        .record_trigger(record_trigger),
        .speaker_out(speaker_out),
        .impulse_done(impulse_done),
        .busy()
    );

    // each block refuses a request on its own state
    impulse_recorder i_recorder (
        .audio_clk(audio_clk),
        .rst_in(rst_in),
        .audio_trigger(audio_trigger),
        .record_trigger(record_trigger),
        .impulse_done(impulse_done),
        .delay_length(delay_length),
        .mic_in(mic_in),
        .wr_en(wr_en),
        .wr_line(wr_line),
        .wr_data(wr_data),
        .impulse_recorded(impulse_recorded),
        .busy()
    );

    impulse_line_store i_line_store (
        .audio_clk(audio_clk),
        .rst_in(rst_in),
        .wr_en(wr_en),
        .wr_line(wr_line),
        .wr_data(wr_data),
        .rd_req(rd_req),
        .rd_line(rd_line),
        .rd_ack(rd_ack),
        .rd_data(rd_data)
    );

endmodule

`default_nettype wire

//--- source/impulse_line_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "impulse_defines.svh"

module impulse_line_store (
    input wire audio_clk,
    input wire rst_in,
    input wire wr_en,
    input wire impulse_pkg::line_addr_t wr_line,
    input wire impulse_pkg::line_t wr_data,
    input wire rd_req,
    input wire impulse_pkg::line_addr_t rd_line,
    output logic rd_ack,
    output impulse_pkg::line_t rd_data
);

    localparam int addr_bits = $clog2(`NUM_LINES);

    impulse_pkg::line_t mem [`NUM_LINES];

    logic [addr_bits-1:0] wr_sel;
    logic [addr_bits-1:0] rd_sel;
    logic rd_start;

    // only the low index bits select a line
    assign wr_sel = wr_line[addr_bits-1:0];
    assign rd_sel = rd_line[addr_bits-1:0];

    // first cycle of a request
    assign rd_start = rd_req && !rd_ack;

    always_ff @(posedge audio_clk) begin
        if (wr_en) begin
            mem[wr_sel] <= wr_data;
        end
    end

    // latched once per request and held through the ack
    always_ff @(posedge audio_clk) begin
        if (rd_start) begin
            rd_data <= mem[rd_sel];
        end
    end

    // four-phase ack
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            rd_ack <= 1'b0;
        end else if (rd_start) begin
            rd_ack <= 1'b1;
        end else if (!rd_req) begin
            rd_ack <= 1'b0;
        end
    end

    // host holds the line index until acknowledged
    assert property (@(posedge audio_clk) disable iff (rst_in)
        (rd_req && !rd_ack) |=> $stable(rd_line));

endmodule

`default_nettype wire

//--- source/impulse_recorder.sv
`timescale 1ns/1ps
`default_nettype none

`include "impulse_defines.svh"

module impulse_recorder (
    input wire audio_clk,
    input wire rst_in,
    input wire audio_trigger,
    input wire record_trigger,
    input wire impulse_done,
    input wire impulse_pkg::delay_t delay_length,
    input wire impulse_pkg::sample_t mic_in,
    output logic wr_en,
    output impulse_pkg::line_addr_t wr_line,
    output impulse_pkg::line_t wr_data,
    output logic impulse_recorded,
    output logic busy
);

    localparam impulse_pkg::line_addr_t last_line =
        impulse_pkg::line_addr_t'(`IMPULSE_LENGTH / `WORDS_PER_LINE - 1);
    localparam impulse_pkg::word_idx_t last_word =
        impulse_pkg::word_idx_t'(`WORDS_PER_LINE - 1);

    impulse_pkg::rec_state_t state;
    impulse_pkg::delay_t delay_cnt;
    impulse_pkg::word_idx_t word_idx;
    impulse_pkg::line_addr_t line_idx;
    impulse_pkg::line_t line_reg;
    impulse_pkg::line_t line_next;
    logic retrig_ignored;

    assign busy = (state != impulse_pkg::REC_WAIT_IMPULSE);

    // newest sample enters at the bottom, older ones move up
    assign line_next = {line_reg[`LINE_WIDTH-`SAMPLE_WIDTH-1:0], mic_in};

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state <= impulse_pkg::REC_WAIT_IMPULSE;
            delay_cnt <= '0;
            word_idx <= '0;
            line_idx <= '0;
            wr_en <= 1'b0;
            wr_line <= '0;
            impulse_recorded <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            // done one clock after the last line write
            if (wr_en && wr_line == last_line) begin
                impulse_recorded <= 1'b1;
            end
            case (state)
                impulse_pkg::REC_WAIT_IMPULSE: begin
                    delay_cnt <= '0;
                    word_idx <= '0;
                    line_idx <= '0;
                    if (record_trigger) begin
                        impulse_recorded <= 1'b0;
                    end else if (impulse_done && !impulse_recorded) begin
                        if (delay_length == '0) begin
                            state <= impulse_pkg::REC_RECORD;
                        end else begin
                            state <= impulse_pkg::REC_DELAY;
                        end
                    end
                end
                impulse_pkg::REC_DELAY: begin
                    // skip delay_length triggers
                    if (audio_trigger) begin
                        if (delay_cnt == delay_length - 16'd1) begin
                            state <= impulse_pkg::REC_RECORD;
                        end else begin
                            delay_cnt <= delay_cnt + 1'b1;
                        end
                    end
                end
                impulse_pkg::REC_RECORD: begin
                    if (audio_trigger) begin
                        word_idx <= word_idx + 1'b1;
                        if (word_idx == last_word) begin
                            wr_en <= 1'b1;
                            wr_line <= line_idx;
                            line_idx <= line_idx + 1'b1;
                            if (line_idx == last_line) begin
                                state <= impulse_pkg::REC_WAIT_IMPULSE;
                            end
                        end
                    end
                end
                default: begin
                    state <= impulse_pkg::REC_WAIT_IMPULSE;
                end
            endcase
        end
    end

    // line assembly and write data
    always_ff @(posedge audio_clk) begin
        if (state == impulse_pkg::REC_RECORD && audio_trigger) begin
            line_reg <= line_next;
            if (word_idx == last_word) begin
                wr_data <= line_next;
            end
        end
    end

    // a request refused here still arms an idle generator
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            retrig_ignored <= 1'b0;
        end else if (record_trigger) begin
            retrig_ignored <= busy;
        end
    end

    // store depth lives in the line store
    assert property (@(posedge audio_clk) disable iff (rst_in)
        wr_en |-> (wr_line < `NUM_LINES));

    // a stray impulse only follows a request this block refused
    assert property (@(posedge audio_clk) disable iff (rst_in)
        impulse_done |-> (state == impulse_pkg::REC_WAIT_IMPULSE) || retrig_ignored);

endmodule

`default_nettype wire

//--- source/impulse_generator.sv
`timescale 1ns/1ps
`default_nettype none

`include "impulse_defines.svh"

module impulse_generator (
    input wire audio_clk,
    input wire rst_in,
    input wire audio_trigger,
    input wire record_trigger,
    output impulse_pkg::sample_t speaker_out,
    output logic impulse_done,
    output logic busy
);

    impulse_pkg::gen_state_t state;

    assign busy = (state != impulse_pkg::GEN_IDLE);

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state <= impulse_pkg::GEN_IDLE;
            speaker_out <= '0;
            impulse_done <= 1'b0;
        end else begin
            impulse_done <= 1'b0;
            case (state)
                impulse_pkg::GEN_IDLE: begin
                    speaker_out <= '0;
                    if (record_trigger) begin
                        state <= impulse_pkg::GEN_ARMED;
                    end
                end
                impulse_pkg::GEN_ARMED: begin
                    // impulse starts on a sample boundary
                    if (audio_trigger) begin
                        speaker_out <= impulse_pkg::sample_t'(`IMPULSE_AMP);
                        state <= impulse_pkg::GEN_PULSE;
                    end
                end
                impulse_pkg::GEN_PULSE: begin
                    // exactly one sample period of full scale
                    if (audio_trigger) begin
                        speaker_out <= '0;
                        impulse_done <= 1'b1;
                        state <= impulse_pkg::GEN_IDLE;
                    end
                end
                default: begin
                    speaker_out <= '0;
                    state <= impulse_pkg::GEN_IDLE;
                end
            endcase
        end
    end

    // recorder relies on a single-cycle done
    assert property (@(posedge audio_clk) disable iff (rst_in)
        impulse_done |=> !impulse_done);

endmodule

`default_nettype wire

//--- source/impulse_pkg.sv
`include "impulse_defines.svh"

package impulse_pkg;

    // audio sample as seen at the codec
    typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

    // packed line, first sample in the top word
    typedef logic [`LINE_WIDTH-1:0] line_t;

    typedef logic [`LINE_ADDR_WIDTH-1:0] line_addr_t;

    // delay in sample periods
    typedef logic [15:0] delay_t;

    // word position inside a line
    typedef logic [$clog2(`WORDS_PER_LINE)-1:0] word_idx_t;

    typedef enum logic [1:0] {
        GEN_IDLE,
        GEN_ARMED,
        GEN_PULSE
    } gen_state_t;

    typedef enum logic [1:0] {
        REC_WAIT_IMPULSE,
        REC_DELAY,
        REC_RECORD
    } rec_state_t;

endpackage

//--- source/impulse_defines.svh
`ifndef IMPULSE_DEFINES_SVH
`define IMPULSE_DEFINES_SVH

// one audio sample, signed
`define SAMPLE_WIDTH 16

// samples packed into one memory line
`define WORDS_PER_LINE 64

// SAMPLE_WIDTH * WORDS_PER_LINE
`define LINE_WIDTH 1024

// samples per capture, a whole number of lines
`define IMPULSE_LENGTH 128

// lines held by the store
`define NUM_LINES 2

// line index width on both ports
`define LINE_ADDR_WIDTH 4

// full-scale positive sample
`define IMPULSE_AMP 16'sh7fff

`endif
